// ==== src.f ====
organ_pkg.sv
timebase.sv
note_tone_gen.sv
led_sweep.sv
key_repeat.sv
sample_rate_ctrl.sv
hex_display.sv
organ_top.sv
tb_clock_gen.sv
tb_organ.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_organ
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_organ.sv ====
`timescale 1ns/1ps

module tb_organ;

  localparam int clk_per_ms  = 10;
  localparam int display_ms  = 4;
  localparam int repeat_ms   = 2;
  localparam int speed_step  = 100;
  localparam int count_reset = 12499;

  logic        CLK_50M;
  logic        reset;
  logic [9:0]  sw;
  logic [3:0]  key;
  logic [7:0]  led;
  logic [6:0]  hex_out [0:5];
  logic        tone;
  logic [7:0]  audio_sample;
  logic [15:0] sample_count;

  int    seed;
  int    error_count;
  int    check_count;
  int    tests_run;
  int    tests_failed;
  int    test_errors;
  string test_name;
  int    cycle_count;
  int    cycle_limit;

  tb_clock_gen u_clock_gen (
    .CLK_50M (CLK_50M),
    .reset   (reset)
  );

  organ_top #(
    .clk_per_ms (clk_per_ms),
    .display_ms (display_ms),
    .repeat_ms  (repeat_ms),
    .speed_step (speed_step)
  ) dut0 (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sw           (sw),
    .key          (key),
    .led          (led),
    .hex0         (hex_out[0]),
    .hex1         (hex_out[1]),
    .hex2         (hex_out[2]),
    .hex3         (hex_out[3]),
    .hex4         (hex_out[4]),
    .hex5         (hex_out[5]),
    .tone         (tone),
    .audio_sample (audio_sample),
    .sample_count (sample_count)
  );

  // ==============================
  // Reference model
  // ==============================

  function automatic int expected_half_period(input int note);
    case (note)
      0: return 47800;
      1: return 42590;
      2: return 37936;
      3: return 35817;
      4: return 31929;
      5: return 28409;
      6: return 25329;
      7: return 23900;
      default: return 0;
    endcase
  endfunction

  // Up the row and back with no repeat at the ends
  function automatic logic [7:0] expected_led(input int pos);
    if (pos < 8)
      return 8'(1 << pos);
    else
      return 8'(1 << (14 - pos));
  endfunction

  function automatic logic [6:0] expected_glyph(input logic [3:0] nibble);
    logic [6:0] lit;
    case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      4'hF: lit = 7'h71;
    endcase
    // Segments are active low
    return ~lit;
  endfunction

  function automatic logic [15:0] expected_count(input int steps);
    return 16'(count_reset + steps * speed_step);
  endfunction

  function automatic logic [7:0] expected_sample(input logic level);
    return level ? 8'h7F : 8'h80;
  endfunction

  // ==============================
  // Checks and bookkeeping
  // ==============================

  task automatic step_cycle();
    @(posedge CLK_50M);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count == test_errors)
      $display("test %s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, error_count - test_errors);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("Mismatch in %s, %s: expected 'h%0h, actual 'h%0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond)
    else
    begin
      error_count++;
      $display("Error in %s: %s", test_name, what);
    end
  endtask

  // ==============================
  // Test steps
  // ==============================

  task automatic check_reset_state();
    check_value("led", 32'h01, {24'h0, led});
    for (int k = 0; k < 6; k++)
      check_value($sformatf("hex%0d", k), {25'h0, expected_glyph(4'h0)}, {25'h0, hex_out[k]});
    check_value("sample count", count_reset, {16'h0, sample_count});
    check_value("audio sample", 32'h80, {24'h0, audio_sample});
  endtask

  task automatic check_led_sweep(input int changes);
    logic [7:0] last;
    int         pos;
    int         seen;
    last = led;
    pos  = 0;
    seen = 0;
    while (seen < changes)
    begin
      step_cycle();
      if (led !== last)
      begin
        pos = (pos + 1) % 14;
        seen++;
        check_value("led", {24'h0, expected_led(pos)}, {24'h0, led});
        last = led;
      end
    end
  endtask

  // Counts cycles up to the next tone edge
  task automatic next_tone_edge(input logic check_sample, output int cycles);
    logic start;
    logic last;
    start  = tone;
    last   = tone;
    cycles = 0;
    while (tone == start)
    begin
      step_cycle();
      cycles++;
      // Sample lags the level by one cycle
      if (check_sample)
        check_value("audio sample", {24'h0, expected_sample(last)}, {24'h0, audio_sample});
      last = tone;
    end
  endtask

  task automatic check_note(input int note);
    int cycles;
    sw[3:1] = 3'(note);
    sw[0]   = 1'b1;
    step_cycle();
    // First edges may fall mid period after the note change
    next_tone_edge(1'b0, cycles);
    next_tone_edge(1'b0, cycles);
    repeat (2)
    begin
      next_tone_edge(1'b1, cycles);
      check_value("half period", expected_half_period(note), cycles);
    end
  endtask

  task automatic check_tone_off(input int note);
    sw[0] = 1'b0;
    step_cycle();
    step_cycle();
    repeat (3 * expected_half_period(note))
    begin
      check_value("tone level", 0, {31'h0, tone});
      check_value("audio sample", 32'h80, {24'h0, audio_sample});
      step_cycle();
    end
  endtask

  task automatic track_key(input int idx, input int hold, input int dir, inout int net);
    logic [15:0] last;
    int          moves;
    moves    = 0;
    last     = sample_count;
    key[idx] = 1'b0;
    // Extra cycles let a pending step drain after release
    for (int c = 0; c < hold + 12; c++)
    begin
      step_cycle();
      if (c == hold)
        key[idx] = 1'b1;
      if (sample_count !== last)
      begin
        net += dir;
        moves++;
        check_value("sample count", {16'h0, expected_count(net)}, {16'h0, sample_count});
        last = sample_count;
      end
    end
    check_true(moves > 0, "sample count never moved while the key was held");
  endtask

  task automatic check_display(input int net);
    logic [23:0] value24;
    repeat (2 * clk_per_ms * display_ms + 4) step_cycle();
    value24 = {8'h00, expected_count(net)};
    for (int k = 0; k < 6; k++)
      check_value($sformatf("hex%0d", k), {25'h0, expected_glyph(value24[4*k +: 4])},
                  {25'h0, hex_out[k]});
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial
  begin
    int order [0:7];
    int pick;
    int swap;
    int net;
    seed         = 32'h52dad8b2;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    net          = 0;
    sw           = '0;
    key          = 4'hF;

    wait (reset === 1'b0);
    step_cycle();

    start_test("reset");
    check_reset_state();
    finish_test();

    start_test("led sweep");
    check_led_sweep(16);
    finish_test();

    // Random note order from the fixed seed
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)
    begin
      pick        = {$random(seed)} % (i + 1);
      swap        = order[i];
      order[i]    = order[pick];
      order[pick] = swap;
    end
    for (int i = 0; i < 8; i++)
    begin
      start_test($sformatf("note %0d", order[i]));
      check_note(order[i]);
      finish_test();
    end

    start_test("tone off");
    check_tone_off(order[7]);
    finish_test();

    start_test("key up");
    track_key(0, 100, 1, net);
    finish_test();

    start_test("key down");
    track_key(1, 140, -1, net);
    finish_test();

    start_test("display");
    check_display(net);
    finish_test();

    start_test("key reset");
    key[2] = 1'b0;
    repeat (4) step_cycle();
    key[2] = 1'b1;
    repeat (8) step_cycle();
    net = 0;
    check_value("sample count", {16'h0, expected_count(net)}, {16'h0, sample_count});
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // ==============================
  // Watchdog
  // ==============================

  // Four edges per note plus the tone off span and slack for the short tests
  initial
  begin
    cycle_count = 0;
    cycle_limit = 20000;
    for (int n = 0; n < 8; n++)
      cycle_limit += 4 * expected_half_period(n);
    cycle_limit += 4 * expected_half_period(0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge CLK_50M);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period_ns = 10,
  parameter int reset_cycles   = 4
) (
  output logic CLK_50M,
  output logic reset
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever
      #(half_period_ns) CLK_50M = ~CLK_50M;
  end

  // Released just after an edge, like the other inputs
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge CLK_50M);
    #1 reset = 1'b0;
  end

endmodule

// ==== organ_top.sv ====
`timescale 1ns/1ps

module organ_top #(
  parameter int clk_per_ms = 50000,
  parameter int display_ms = 500,
  parameter int repeat_ms  = 100,
  parameter int speed_step = 100
) (
  input  logic               CLK_50M,
  input  logic               reset,
  input  logic [9:0]         sw,
  input  logic [3:0]         key,
  output organ_pkg::led_t    led,
  output organ_pkg::seg_t    hex0,
  output organ_pkg::seg_t    hex1,
  output organ_pkg::seg_t    hex2,
  output organ_pkg::seg_t    hex3,
  output organ_pkg::seg_t    hex4,
  output organ_pkg::seg_t    hex5,
  output logic               tone,
  output organ_pkg::sample_t audio_sample,
  output organ_pkg::count_t  sample_count
);

  logic ms_tick;
  logic disp_tick;
  logic step_up;
  logic step_down;
  logic speed_clear;

  // ==============================
  // Time base
  // ==============================

  timebase #(
    .clk_per_ms (clk_per_ms),
    .display_ms (display_ms)
  ) u_timebase (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .ms_tick   (ms_tick),
    .disp_tick (disp_tick)
  );

  // ==============================
  // Tone path
  // ==============================

  // sw[0] enables, sw[3:1] picks the note
  note_tone_gen u_note_tone_gen (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .tone_en      (sw[0]),
    .note         (sw[3:1]),
    .tone         (tone),
    .audio_sample (audio_sample)
  );

  led_sweep u_led_sweep (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .disp_tick (disp_tick),
    .led       (led)
  );

  // ==============================
  // Sampling count control
  // ==============================

  // key[0] up, key[1] down, key[2] back to default
  key_repeat #(
    .repeat_ms (repeat_ms)
  ) u_key_repeat (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .ms_tick     (ms_tick),
    .key_n       (key[2:0]),
    .step_up     (step_up),
    .step_down   (step_down),
    .speed_clear (speed_clear)
  );

  sample_rate_ctrl #(
    .speed_step (speed_step)
  ) u_sample_rate_ctrl (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .step_up      (step_up),
    .step_down    (step_down),
    .speed_clear  (speed_clear),
    .sample_count (sample_count)
  );

  hex_display u_hex_display (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .disp_tick (disp_tick),
    .value     (sample_count),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

endmodule

// ==== hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic              disp_tick,
  input  organ_pkg::count_t value,
  output organ_pkg::seg_t   hex0,
  output organ_pkg::seg_t   hex1,
  output organ_pkg::seg_t   hex2,
  output organ_pkg::seg_t   hex3,
  output organ_pkg::seg_t   hex4,
  output organ_pkg::seg_t   hex5
);

  logic [23:0]     shown;
  organ_pkg::seg_t seg [0:5];

  // ==============================
  // Display latch
  // ==============================

  // Refreshes only on the display tick so digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      shown <= '0;
    else if (disp_tick)
      shown <= {8'h00, value};
  end

  // ==============================
  // Nibble decoders
  // ==============================

  for (genvar k = 0; k < 6; k++)
  begin : g_digit
    assign seg[k] = organ_pkg::hex_seg[shown[4*k +: 4]];
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

// ==== sample_rate_ctrl.sv ====
`timescale 1ns/1ps

module sample_rate_ctrl #(
  parameter int speed_step = 100
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic              step_up,
  input  logic              step_down,
  input  logic              speed_clear,
  output organ_pkg::count_t sample_count
);

  localparam organ_pkg::speed_t step_val = 16'(speed_step);

  organ_pkg::speed_t offset;

  // Signed offset, wraps modulo 2^16
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_clear)
      offset <= '0;
    else
    begin
      case ({step_up, step_down})
        2'b10:   offset <= offset + step_val;
        2'b01:   offset <= offset - step_val;
        // Both or neither leaves it alone
        default: offset <= offset;
      endcase
    end
  end

  // ==============================
  // Registered sampling count
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_count <= organ_pkg::default_count;
    else
      sample_count <= organ_pkg::default_count + organ_pkg::count_t'(offset);
  end

endmodule

// ==== key_repeat.sv ====
`timescale 1ns/1ps

module key_repeat #(
  parameter int repeat_ms = 100
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       ms_tick,
  input  logic [2:0] key_n,
  output logic       step_up,
  output logic       step_down,
  output logic       speed_clear
);

  localparam int win_w = $clog2(repeat_ms + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [2:0]       held;
  logic [win_w-1:0] win_cnt;
  logic             win_end;

  // ==============================
  // Button synchronizers
  // ==============================

  // Keys idle high, so reset loads the released state
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  assign held = ~key_sync;

  // ==============================
  // Repeat window
  // ==============================

  assign win_end = ms_tick && (win_cnt == win_w'(repeat_ms - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      win_cnt <= '0;
    else if (win_end)
      win_cnt <= '0;
    else if (ms_tick)
      win_cnt <= win_cnt + 1'b1;
  end

  // At most one step per window while held
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end
    else
    begin
      step_up   <= win_end & held[0];
      step_down <= win_end & held[1];
    end
  end

  // Reset key acts as a plain level
  assign speed_clear = held[2];

endmodule

// ==== led_sweep.sv ====
`timescale 1ns/1ps

module led_sweep (
  input  logic             CLK_50M,
  input  logic             reset,
  input  logic             disp_tick,
  output organ_pkg::led_t  led
);

  localparam int pos_w = $clog2(organ_pkg::led_steps);

  logic             half;
  logic [pos_w-1:0] pos;

  // Half rate, one step per two display ticks
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      half <= 1'b0;
    else if (disp_tick)
      half <= ~half;
  end

  // Position in the bounce table
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      pos <= '0;
    else if (disp_tick && half)
    begin
      if (pos == pos_w'(organ_pkg::led_steps - 1))
        pos <= '0;
      else
        pos <= pos + 1'b1;
    end
  end

  assign led = organ_pkg::led_pattern[pos];

endmodule

// ==== note_tone_gen.sv ====
`timescale 1ns/1ps

module note_tone_gen (
  input  logic                CLK_50M,
  input  logic                reset,
  input  logic                tone_en,
  input  organ_pkg::note_sel_t note,
  output logic                tone,
  output organ_pkg::sample_t  audio_sample
);

  organ_pkg::half_period_t half_period;
  organ_pkg::half_period_t div_cnt;
  logic                    tone_lvl;

  assign half_period = organ_pkg::note_half_period[note];

  // ==============================
  // Half-period divider
  // ==============================

  // Compare with >= so a switch to a shorter note
  // does not run the counter all the way around
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      div_cnt  <= '0;
      tone_lvl <= 1'b0;
    end
    else if (div_cnt >= half_period - 32'd1)
    begin
      div_cnt  <= '0;
      tone_lvl <= ~tone_lvl;
    end
    else
      div_cnt <= div_cnt + 32'd1;
  end

  // Enable gates the output only, divider keeps running
  assign tone = tone_lvl & tone_en;

  // ==============================
  // Signed audio sample
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      audio_sample <= organ_pkg::sample_low;
    else if (tone)
      audio_sample <= organ_pkg::sample_high;
    else
      audio_sample <= organ_pkg::sample_low;
  end

endmodule

// ==== timebase.sv ====
`timescale 1ns/1ps

module timebase #(
  parameter int clk_per_ms = 50000,
  parameter int display_ms = 500
) (
  input  logic CLK_50M,
  input  logic reset,
  output logic ms_tick,
  output logic disp_tick
);

  localparam int ms_w   = $clog2(clk_per_ms + 1);
  localparam int disp_w = $clog2(display_ms + 1);

  logic [ms_w-1:0]   ms_cnt;
  logic [disp_w-1:0] disp_cnt;

  // Millisecond strobe from the system clock
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      ms_cnt  <= '0;
      ms_tick <= 1'b0;
    end
    else if (ms_cnt == ms_w'(clk_per_ms - 1))
    begin
      ms_cnt  <= '0;
      ms_tick <= 1'b1;
    end
    else
    begin
      ms_cnt  <= ms_cnt + 1'b1;
      ms_tick <= 1'b0;
    end
  end

  // Display strobe, counts millisecond strobes
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      disp_cnt  <= '0;
      disp_tick <= 1'b0;
    end
    else
    begin
      disp_tick <= 1'b0;
      if (ms_tick)
      begin
        if (disp_cnt == disp_w'(display_ms - 1))
        begin
          disp_cnt  <= '0;
          disp_tick <= 1'b1;
        end
        else
          disp_cnt <= disp_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== organ_pkg.sv ====
package organ_pkg;

  // ==============================
  // Tone generation
  // ==============================

  typedef logic [2:0] note_sel_t;
  typedef logic [31:0] half_period_t;

  // Half periods in 50 MHz cycles, Do up to Do2
  localparam half_period_t note_half_period [0:7] = '{
    32'd47800,
    32'd42590,
    32'd37936,
    32'd35817,
    32'd31929,
    32'd28409,
    32'd25329,
    32'd23900
  };

  typedef logic signed [7:0] sample_t;

  localparam sample_t sample_high = 8'h7F;
  localparam sample_t sample_low  = 8'h80;

  // ==============================
  // LED bounce
  // ==============================

  typedef logic [7:0] led_t;

  localparam int led_steps = 14;

  // Up from bit 0 to bit 7, then back down, ends meet without repeat
  localparam led_t led_pattern [0:led_steps-1] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80,
    8'h40, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02
  };

  // ==============================
  // Sampling count and display
  // ==============================

  typedef logic signed [15:0] speed_t;
  typedef logic [15:0] count_t;

  localparam count_t default_count = 16'd12499;

  // Segments active low, bit 0 is a
  typedef logic [6:0] seg_t;

  localparam seg_t hex_seg [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage
